//--- commit_top.f
design/rv_arch_pkg.sv
design/commit_pkg.sv
design/unit_result_slot.sv
design/commit_select.sv
design/commit_regfile.sv
design/commit_trap_ctrl.sv
design/commit_top.sv
test/commit_tb.sv

//--- design/commit_pkg.sv
package commit_pkg;

  // Issue order, wraps after 8 instructions in flight
  typedef logic [2:0] insn_token;

  // What the core must do besides writeback
  typedef struct packed {
    logic trap;
    logic flush;
    logic mode_return;
    logic wait_irq;
    logic spare;
  } commit_action_t;

  // Fields filled at issue time
  typedef struct packed {
    insn_token           token;
    rv_arch_pkg::reg_addr rd_addr;
    rv_arch_pkg::reg_mask rd_mask;
  } commit_common_t;

  // Full record delivered by an execution unit
  typedef struct packed {
    commit_common_t          common;
    commit_action_t          action;
    logic                    writeback;
    rv_arch_pkg::word        result;
    rv_arch_pkg::word        next_pc;
    rv_arch_pkg::exception_t exception_cause;
    rv_arch_pkg::word        exception_value;
  } commit_data_t;

  localparam int NUM_UNITS = 4;

  // Position of each unit in the unit vectors
  typedef enum logic [1:0] {
    UNIT_ALU        = 2'd0,
    UNIT_BRANCH     = 2'd1,
    UNIT_CTRLSTATUS = 2'd2,
    UNIT_MEM        = 2'd3
  } unit_idx_t;

endpackage

//--- design/commit_regfile.sv
`timescale 1ns/10ps

module commit_regfile (
  input  logic                 clk_core,
  input  logic                 rst_core_n,

  // Write port from the commit selector
  input  logic                 wr_en_i,
  input  rv_arch_pkg::reg_addr wr_addr_i,
  input  rv_arch_pkg::word     wr_data_i,
  input  rv_arch_pkg::reg_mask commit_mask_i,

  // Issue side scoreboard update
  input  logic                 issue_i,
  input  rv_arch_pkg::reg_mask issue_mask_i,

  // Debug read port
  input  rv_arch_pkg::reg_addr dbg_addr_i,
  output rv_arch_pkg::word     dbg_data_o,

  output rv_arch_pkg::reg_mask busy_mask_o
);

  import rv_arch_pkg::*;

  word     regs_q [NUM_REGS];
  reg_mask set_mask;
  reg_mask busy_q;

  // x0 is hardwired, never stored
  always_ff @(posedge clk_core) begin
    if (wr_en_i && wr_addr_i != '0) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs_q[dbg_addr_i];

  assign set_mask = issue_i ? issue_mask_i : '0;

  // Retirement clear takes priority over a same-cycle issue
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      busy_q <= '0;
    end else begin
      busy_q <= (busy_q | set_mask) & ~commit_mask_i;
    end
  end

  assign busy_mask_o = busy_q;

endmodule

//--- design/commit_select.sv
`timescale 1ns/10ps

module commit_select (
  input  logic                     clk_core,
  input  logic                     rst_core_n,

  // Result slots
  input  logic [commit_pkg::NUM_UNITS-1:0] unit_valid_i,
  input  commit_pkg::commit_data_t         unit_data_i [commit_pkg::NUM_UNITS],
  output logic [commit_pkg::NUM_UNITS-1:0] unit_ready_o,
  output logic [commit_pkg::NUM_UNITS-1:0] retire_o,

  // Flush handshake
  input  logic                     flush_req_i,
  input  rv_arch_pkg::word         flush_target_i,
  output logic                     flush_ack_o,

  // Trap controller
  input  logic                     ctrl_begin_irq_i,
  output logic                     ctrl_flush_begin_o,
  output logic                     ctrl_trap_o,
  output rv_arch_pkg::exception_t  ctrl_trap_cause_o,
  output rv_arch_pkg::word         ctrl_trap_value_o,
  output logic                     ctrl_mode_return_o,
  output logic                     ctrl_wait_irq_o,
  output rv_arch_pkg::word         ctrl_next_pc_o,
  output logic                     ctrl_commit_o,

  // Register file and scoreboard
  output logic                     wr_en_o,
  output rv_arch_pkg::reg_addr     wr_addr_o,
  output rv_arch_pkg::word         wr_data_o,
  output rv_arch_pkg::reg_mask     commit_mask_o,

  output commit_pkg::insn_token    token_o
);

  import rv_arch_pkg::*;
  import commit_pkg::*;

  logic [NUM_UNITS-1:0] committable;
  commit_data_t         used_data;
  commit_action_t       action;
  logic                 accept;
  logic                 general_commit;
  logic                 token_enable;
  logic                 token_clear;

  // Only the unit holding the current token may retire
  always_comb begin
    used_data = '0;
    for (int i = 0; i < NUM_UNITS; i++) begin
      unit_ready_o[i] = unit_data_i[i].common.token == token_o;
      committable[i]  = unit_ready_o[i] & unit_valid_i[i];
      retire_o[i]     = committable[i] & ~unit_data_i[i].action.trap;
      if (committable[i]) begin
        used_data = commit_data_t'(used_data | unit_data_i[i]);
      end
    end
  end

  assign action         = used_data.action;
  assign accept         = |committable;
  assign general_commit = |retire_o;
  assign ctrl_commit_o  = general_commit;

  assign ctrl_flush_begin_o = action.flush;

  // Trapping instruction leaves no architectural trace
  assign wr_en_o       = used_data.writeback & ~action.trap;
  assign wr_addr_o     = used_data.common.rd_addr;
  assign wr_data_o     = used_data.result;
  assign commit_mask_o = action.trap ? '0 : used_data.common.rd_mask;

  assign token_enable = general_commit & ~action.flush & ~ctrl_begin_irq_i;
  // Second cycle of the handshake, request already dropped
  assign token_clear  = flush_ack_o & ~flush_req_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      token_o            <= '0;
      flush_ack_o        <= 1'b1;
      ctrl_trap_o        <= 1'b0;
      ctrl_trap_cause_o  <= exception_t'('0);
      ctrl_trap_value_o  <= '0;
      ctrl_mode_return_o <= 1'b0;
      ctrl_wait_irq_o    <= 1'b0;
      ctrl_next_pc_o     <= '0;
    end else begin
      flush_ack_o        <= flush_req_i;
      ctrl_trap_o        <= action.trap;
      ctrl_trap_cause_o  <= used_data.exception_cause;
      ctrl_trap_value_o  <= used_data.exception_value;
      ctrl_mode_return_o <= action.mode_return;
      ctrl_wait_irq_o    <= action.wait_irq;

      if (token_clear) begin
        token_o        <= '0;
        ctrl_next_pc_o <= flush_target_i;
      end else begin
        if (token_enable) begin
          token_o <= token_o + 1'b1;
        end
        // Trap attempts too, mepc is taken from here
        if (accept) begin
          ctrl_next_pc_o <= used_data.next_pc;
        end
      end
    end
  end

  // Tokens in flight are unique across the slots
  a_single_retire: assert property (
    @(posedge clk_core) disable iff (!rst_core_n)
    $onehot0(committable)
  ) else $error("more than one unit holds the current token");

endmodule

//--- design/commit_top.sv
`timescale 1ns/10ps

module commit_top (
  input  logic                             clk_core,
  input  logic                             rst_core_n,

  // Execution unit results
  input  logic [commit_pkg::NUM_UNITS-1:0] unit_result_valid_i,
  input  commit_pkg::commit_data_t         unit_result_i [commit_pkg::NUM_UNITS],
  output logic [commit_pkg::NUM_UNITS-1:0] unit_full_o,

  // Issue side
  input  logic                             issue_i,
  input  rv_arch_pkg::reg_mask             issue_mask_i,
  input  logic                             irq_i,

  input  rv_arch_pkg::reg_addr             dbg_addr_i,
  output rv_arch_pkg::word                 dbg_data_o,
  output rv_arch_pkg::reg_mask             busy_mask_o,

  output commit_pkg::insn_token            token_o,
  output rv_arch_pkg::word                 pc_o,
  output logic [commit_pkg::NUM_UNITS-1:0] retire_o,
  output logic                             flush_o,
  output rv_arch_pkg::word                 mepc_o,
  output rv_arch_pkg::exception_t          mcause_o,
  output rv_arch_pkg::word                 mtval_o,
  output logic                             wait_o
);

  import rv_arch_pkg::*;
  import commit_pkg::*;

  logic [NUM_UNITS-1:0] slot_valid;
  logic [NUM_UNITS-1:0] slot_ready;
  commit_data_t         slot_data [NUM_UNITS];

  logic       wr_en;
  reg_addr    wr_addr;
  word        wr_data;
  reg_mask    commit_mask;
  logic       flush_req;
  word        flush_target;
  logic       ctrl_begin_irq;
  logic       ctrl_flush_begin;
  logic       ctrl_trap;
  exception_t ctrl_trap_cause;
  word        ctrl_trap_value;
  logic       ctrl_mode_return;
  logic       ctrl_wait_irq;
  word        ctrl_next_pc;

  for (genvar i = 0; i < NUM_UNITS; i++) begin : g_slot
    unit_result_slot u_slot (
      .clk_core       (clk_core),
      .rst_core_n     (rst_core_n),
      .result_valid_i (unit_result_valid_i[i]),
      .result_i       (unit_result_i[i]),
      .full_o         (unit_full_o[i]),
      .valid_o        (slot_valid[i]),
      .data_o         (slot_data[i]),
      .ready_i        (slot_ready[i])
    );
  end

  commit_select u_select (
    .clk_core           (clk_core),
    .rst_core_n         (rst_core_n),
    .unit_valid_i       (slot_valid),
    .unit_data_i        (slot_data),
    .unit_ready_o       (slot_ready),
    .retire_o           (retire_o),
    .flush_req_i        (flush_req),
    .flush_target_i     (flush_target),
    .flush_ack_o        (),
    .ctrl_begin_irq_i   (ctrl_begin_irq),
    .ctrl_flush_begin_o (ctrl_flush_begin),
    .ctrl_trap_o        (ctrl_trap),
    .ctrl_trap_cause_o  (ctrl_trap_cause),
    .ctrl_trap_value_o  (ctrl_trap_value),
    .ctrl_mode_return_o (ctrl_mode_return),
    .ctrl_wait_irq_o    (ctrl_wait_irq),
    .ctrl_next_pc_o     (ctrl_next_pc),
    .ctrl_commit_o      (),
    .wr_en_o            (wr_en),
    .wr_addr_o          (wr_addr),
    .wr_data_o          (wr_data),
    .commit_mask_o      (commit_mask),
    .token_o            (token_o)
  );

  commit_regfile u_regfile (
    .clk_core      (clk_core),
    .rst_core_n    (rst_core_n),
    .wr_en_i       (wr_en),
    .wr_addr_i     (wr_addr),
    .wr_data_i     (wr_data),
    .commit_mask_i (commit_mask),
    .issue_i       (issue_i),
    .issue_mask_i  (issue_mask_i),
    .dbg_addr_i    (dbg_addr_i),
    .dbg_data_o    (dbg_data_o),
    .busy_mask_o   (busy_mask_o)
  );

  commit_trap_ctrl u_trap_ctrl (
    .clk_core           (clk_core),
    .rst_core_n         (rst_core_n),
    .ctrl_flush_begin_i (ctrl_flush_begin),
    .ctrl_trap_i        (ctrl_trap),
    .ctrl_trap_cause_i  (ctrl_trap_cause),
    .ctrl_trap_value_i  (ctrl_trap_value),
    .ctrl_mode_return_i (ctrl_mode_return),
    .ctrl_wait_irq_i    (ctrl_wait_irq),
    .ctrl_next_pc_i     (ctrl_next_pc),
    .irq_i              (irq_i),
    .flush_req_o        (flush_req),
    .flush_target_o     (flush_target),
    .ctrl_begin_irq_o   (ctrl_begin_irq),
    .mepc_o             (mepc_o),
    .mtval_o            (mtval_o),
    .mcause_o           (mcause_o),
    .wait_o             (wait_o)
  );

  assign pc_o    = ctrl_next_pc;
  assign flush_o = flush_req;

endmodule

//--- design/commit_trap_ctrl.sv
`timescale 1ns/10ps

module commit_trap_ctrl (
  input  logic                    clk_core,
  input  logic                    rst_core_n,

  // Controls from the commit selector
  input  logic                    ctrl_flush_begin_i,
  input  logic                    ctrl_trap_i,
  input  rv_arch_pkg::exception_t ctrl_trap_cause_i,
  input  rv_arch_pkg::word        ctrl_trap_value_i,
  input  logic                    ctrl_mode_return_i,
  input  logic                    ctrl_wait_irq_i,
  input  rv_arch_pkg::word        ctrl_next_pc_i,

  input  logic                    irq_i,

  // Flush request back to the selector
  output logic                    flush_req_o,
  output rv_arch_pkg::word        flush_target_o,
  output logic                    ctrl_begin_irq_o,

  // Trap state
  output rv_arch_pkg::word        mepc_o,
  output rv_arch_pkg::word        mtval_o,
  output rv_arch_pkg::exception_t mcause_o,
  output logic                    wait_o
);

  import rv_arch_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    FLUSH,
    WAIT_IRQ
  } state_t;

  state_t state_q;
  // Aligns the plain flush with the registered controls
  logic   flush_begin_q;

  assign flush_req_o      = state_q == FLUSH;
  assign wait_o           = state_q == WAIT_IRQ;
  assign ctrl_begin_irq_o = wait_o & irq_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      state_q        <= IDLE;
      flush_begin_q  <= 1'b0;
      flush_target_o <= '0;
      mepc_o         <= '0;
      mtval_o        <= '0;
      mcause_o       <= exception_t'('0);
    end else begin
      flush_begin_q <= ctrl_flush_begin_i;
      case (state_q)
        IDLE: begin
          if (ctrl_trap_i) begin
            mepc_o         <= ctrl_next_pc_i;
            mcause_o       <= ctrl_trap_cause_i;
            mtval_o        <= ctrl_trap_value_i;
            flush_target_o <= TRAP_VECTOR;
            state_q        <= FLUSH;
          end else if (ctrl_mode_return_i) begin
            flush_target_o <= mepc_o;
            state_q        <= FLUSH;
          end else if (flush_begin_q) begin
            flush_target_o <= ctrl_next_pc_i;
            state_q        <= FLUSH;
          end else if (ctrl_wait_irq_i) begin
            state_q <= WAIT_IRQ;
          end
        end
        // Request lasts a single cycle
        FLUSH: state_q <= IDLE;
        WAIT_IRQ: begin
          if (ctrl_begin_irq_o) begin
            mepc_o         <= ctrl_next_pc_i;
            mcause_o       <= IRQ_EXTERNAL;
            mtval_o        <= '0;
            flush_target_o <= TRAP_VECTOR;
            state_q        <= FLUSH;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Events arriving mid-flush would be lost
  a_no_event_during_flush: assert property (
    @(posedge clk_core) disable iff (!rst_core_n)
    flush_req_o |-> !(ctrl_trap_i || ctrl_mode_return_i || flush_begin_q || ctrl_wait_irq_i)
  ) else $error("control event arrived while a flush was requested");

endmodule

//--- design/rv_arch_pkg.sv
package rv_arch_pkg;

  // Data and pc values
  typedef logic [31:0] word;

  typedef logic [4:0] reg_addr;

  // One bit per architectural register
  typedef logic [31:0] reg_mask;

  localparam int NUM_REGS = 32;

  // Trap causes, low bits of mcause
  typedef enum logic [3:0] {
    ILLEGAL_INSN = 4'd2,
    LOAD_FAULT   = 4'd5,
    ECALL        = 4'd8,
    IRQ_EXTERNAL = 4'd11
  } exception_t;

  // Pc loaded on any trap or external interrupt
  localparam word TRAP_VECTOR = 32'h0000_0100;

endpackage

//--- design/unit_result_slot.sv
`timescale 1ns/10ps

module unit_result_slot (
  input  logic                     clk_core,
  input  logic                     rst_core_n,

  // From the execution unit
  input  logic                     result_valid_i,
  input  commit_pkg::commit_data_t result_i,
  output logic                     full_o,

  // Towards the commit selector
  output logic                     valid_o,
  output commit_pkg::commit_data_t data_o,
  input  logic                     ready_i
);

  import commit_pkg::*;

  logic         occupied_q;
  logic         load;
  logic         retire;
  commit_data_t data_q;

  assign load   = result_valid_i & ~occupied_q;
  assign retire = occupied_q & ready_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      occupied_q <= 1'b0;
    end else if (load) begin
      occupied_q <= 1'b1;
    end else if (retire) begin
      occupied_q <= 1'b0;
    end
  end

  // Payload only, qualified by occupied_q
  always_ff @(posedge clk_core) begin
    if (load) begin
      data_q <= result_i;
    end
  end

  assign full_o  = occupied_q;
  assign valid_o = occupied_q;
  assign data_o  = data_q;

  // Unit has to wait for full_o to drop before the next result
  a_no_strobe_when_full: assert property (
    @(posedge clk_core) disable iff (!rst_core_n)
    result_valid_i |-> !occupied_q
  ) else $error("result strobe into a full slot");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module commit_tb \
  -Mdir obj_dir -o commit_sim \
  -f commit_top.f

./obj_dir/commit_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without a reported failure"

//--- test/commit_tb.sv
`timescale 1ns/10ps

module commit_tb;

  import rv_arch_pkg::*;
  import commit_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 120;
  localparam int WAIT_CYCLES = 16;

  logic                 clk_core = 1'b0;
  logic                 rst_core_n;
  logic [NUM_UNITS-1:0] unit_result_valid_i;
  commit_data_t         unit_result_i [NUM_UNITS];
  logic [NUM_UNITS-1:0] unit_full_o;
  logic                 issue_i;
  reg_mask              issue_mask_i;
  logic                 irq_i;
  reg_addr              dbg_addr_i;
  word                  dbg_data_o;
  reg_mask              busy_mask_o;
  insn_token            token_o;
  word                  pc_o;
  logic [NUM_UNITS-1:0] retire_o;
  logic                 flush_o;
  word                  mepc_o;
  exception_t           mcause_o;
  word                  mtval_o;
  logic                 wait_o;

  int        errors    = 0;
  int        checks    = 0;
  word       lcg_state = 32'hf38958bf;
  // Reference model state
  insn_token exp_token = '0;
  reg_mask   exp_busy  = '0;
  word       exp_mepc  = '0;

  commit_top UUT (.*);

  always #(CLK_PERIOD / 2) clk_core = ~clk_core;

  function automatic word lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic commit_data_t make_record(input insn_token tok, input reg_addr rd,
                                               input logic wb, input word result,
                                               input word next_pc);
    commit_data_t rec;
    rec                = '0;
    rec.common.token   = tok;
    rec.common.rd_addr = rd;
    rec.common.rd_mask = wb ? reg_mask'(1) << rd : '0;
    rec.writeback      = wb;
    rec.result         = result;
    rec.next_pc        = next_pc;
    return rec;
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic send_result(input int idx, input commit_data_t rec);
    @(posedge clk_core);
    unit_result_valid_i[idx] <= 1'b1;
    unit_result_i[idx]       <= rec;
    @(posedge clk_core);
    unit_result_valid_i[idx] <= 1'b0;
  endtask

  task automatic issue_regs(input reg_mask mask);
    @(posedge clk_core);
    issue_i      <= 1'b1;
    issue_mask_i <= mask;
    @(posedge clk_core);
    issue_i      <= 1'b0;
    issue_mask_i <= '0;
    exp_busy |= mask;
  endtask

  task automatic read_reg(input reg_addr addr, output word data);
    @(posedge clk_core);
    dbg_addr_i <= addr;
    @(negedge clk_core);
    data = dbg_data_o;
  endtask

  // Waits for the next retirement and expects it from unit idx alone
  task automatic wait_retire(input int idx);
    int n;
    n = 0;
    do begin
      @(negedge clk_core);
      n++;
    end while (retire_o == '0 && n < WAIT_CYCLES);
    if (retire_o == '0) begin
      errors++;
      $display("Unit %0d did not retire within %0d cycles at %0t", idx, WAIT_CYCLES, $time);
    end else begin
      check_equal(retire_o, 32'(1) << idx, "retire_o one-hot");
    end
  endtask

  task automatic commit_result(input int idx, input commit_data_t rec);
    send_result(idx, rec);
    wait_retire(idx);
    exp_token += 3'd1;
    exp_busy &= ~rec.common.rd_mask;
  endtask

  task automatic finish_flush(input word exp_pc, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_core);
      cycles++;
    end while (flush_o !== 1'b1 && cycles < WAIT_CYCLES);
    if (flush_o !== 1'b1) begin
      errors++;
      $display("No flush request seen within %0d cycles at %0t", WAIT_CYCLES, $time);
    end
    @(negedge clk_core);
    check_equal(flush_o, 1'b0, "flush request width");
    // Ack cycle over, token and pc reloaded
    @(negedge clk_core);
    cycles += 2;
    exp_token = '0;
    check_equal(pc_o, exp_pc, "pc after flush");
    check_equal(token_o, exp_token, "token after flush");
  endtask

  task automatic in_order_retirement();
    commit_data_t rec [NUM_UNITS];
    reg_mask      mask;
    word          rnd;
    word          val;
    mask = '0;
    for (int i = 0; i < NUM_UNITS; i++) begin
      rnd = lcg_next();
      // Unit 0 targets x0
      rec[i] = make_record(exp_token + 3'(i), (i == 0) ? 5'd0 : {rnd[4:2], 2'(i)}, 1'b1,
                           lcg_next(), lcg_next());
      mask |= rec[i].common.rd_mask;
    end
    issue_regs(mask);
    for (int i = NUM_UNITS - 1; i > 0; i--) begin
      send_result(i, rec[i]);
    end
    @(negedge clk_core);
    check_equal(unit_full_o, 4'b1110, "later tokens held");
    send_result(0, rec[0]);
    for (int k = 0; k < NUM_UNITS; k++) begin
      wait_retire(k);
      exp_token += 3'd1;
      exp_busy &= ~rec[k].common.rd_mask;
    end
    @(negedge clk_core);
    check_equal(token_o, exp_token, "token after in-order retirement");
    check_equal(busy_mask_o, exp_busy, "busy mask after in-order retirement");
    for (int i = 0; i < NUM_UNITS; i++) begin
      read_reg(rec[i].common.rd_addr, val);
      check_equal(val, (i == 0) ? 32'd0 : rec[i].result, "register after retirement");
    end
  endtask

  task automatic busy_mask_tracking();
    commit_data_t rec [3];
    reg_mask      mask;
    word          rnd;
    mask = '0;
    for (int i = 0; i < 3; i++) begin
      rnd    = lcg_next();
      rec[i] = make_record(exp_token + 3'(i), reg_addr'(8 * i + 1 + int'(rnd % 7)), 1'b1,
                           rnd, lcg_next());
      mask |= rec[i].common.rd_mask;
    end
    issue_regs(mask);
    @(negedge clk_core);
    check_equal(busy_mask_o, exp_busy, "busy mask after issue");
    for (int i = 0; i < 3; i++) begin
      commit_result(i, rec[i]);
      @(negedge clk_core);
      check_equal(busy_mask_o, exp_busy, "busy mask after retirement");
    end
  endtask

  task automatic back_pressure();
    commit_data_t early;
    commit_data_t late;
    late  = make_record(exp_token + 3'd1, 5'd30, 1'b1, lcg_next(), lcg_next());
    early = make_record(exp_token, 5'd29, 1'b1, lcg_next(), lcg_next());
    send_result(UNIT_BRANCH, late);
    repeat (5) begin
      @(negedge clk_core);
      check_equal(unit_full_o[UNIT_BRANCH], 1'b1, "future token keeps its slot full");
      check_equal(retire_o, '0, "no retirement out of order");
    end
    commit_result(UNIT_ALU, early);
    wait_retire(UNIT_BRANCH);
    exp_token += 3'd1;
    exp_busy &= ~late.common.rd_mask;
    @(negedge clk_core);
    check_equal(unit_full_o, '0, "slots empty after back-pressure");
    check_equal(token_o, exp_token, "token after back-pressure");
  endtask

  task automatic trap_entry();
    commit_data_t prior;
    commit_data_t rec;
    word          val;
    int           cycles;
    prior = make_record(exp_token, 5'd28, 1'b1, lcg_next(), lcg_next());
    commit_result(UNIT_MEM, prior);
    rec = make_record(exp_token, 5'd28, 1'b1, lcg_next(), lcg_next());
    rec.action.trap      = 1'b1;
    rec.exception_cause  = LOAD_FAULT;
    rec.exception_value  = lcg_next();
    issue_regs(rec.common.rd_mask);
    send_result(UNIT_MEM, rec);
    @(negedge clk_core);
    check_equal(unit_full_o[UNIT_MEM], 1'b1, "trap record offered");
    check_equal(retire_o, '0, "trap record not retired");
    finish_flush(TRAP_VECTOR, cycles);
    check_equal(cycles, 4, "cycles from trap to token clear");
    exp_mepc = rec.next_pc;
    check_equal(mcause_o, LOAD_FAULT, "mcause after trap");
    check_equal(mtval_o, rec.exception_value, "mtval after trap");
    check_equal(mepc_o, exp_mepc, "mepc after trap");
    check_equal(busy_mask_o, exp_busy, "busy bit kept by trap");
    read_reg(rec.common.rd_addr, val);
    check_equal(val, prior.result, "trap leaves register unwritten");
  endtask

  task automatic return_and_flush();
    commit_data_t rec;
    int           cycles;
    rec = make_record(exp_token, 5'd0, 1'b0, '0, lcg_next());
    rec.action.mode_return = 1'b1;
    commit_result(UNIT_CTRLSTATUS, rec);
    finish_flush(exp_mepc, cycles);
    rec = make_record(exp_token, 5'd0, 1'b0, '0, lcg_next());
    rec.action.flush = 1'b1;
    commit_result(UNIT_BRANCH, rec);
    finish_flush(rec.next_pc, cycles);
  endtask

  task automatic wait_for_irq();
    commit_data_t rec;
    int           cycles;
    rec = make_record(exp_token, 5'd0, 1'b0, '0, lcg_next());
    rec.action.wait_irq = 1'b1;
    commit_result(UNIT_CTRLSTATUS, rec);
    cycles = 0;
    do begin
      @(negedge clk_core);
      cycles++;
    end while (wait_o !== 1'b1 && cycles < WAIT_CYCLES);
    check_equal(wait_o, 1'b1, "wait_o after wait request");
    repeat (3) @(negedge clk_core);
    check_equal(flush_o, 1'b0, "no flush while waiting");
    @(posedge clk_core);
    irq_i <= 1'b1;
    @(posedge clk_core);
    irq_i <= 1'b0;
    finish_flush(TRAP_VECTOR, cycles);
    exp_mepc = rec.next_pc;
    check_equal(mcause_o, IRQ_EXTERNAL, "mcause after interrupt");
    check_equal(mepc_o, exp_mepc, "mepc after interrupt");
    check_equal(wait_o, 1'b0, "wait_o after interrupt");
    check_equal(busy_mask_o, exp_busy, "busy mask at end");
  endtask

  initial begin
    rst_core_n          = 1'b0;
    unit_result_valid_i = '0;
    issue_i             = 1'b0;
    issue_mask_i        = '0;
    irq_i               = 1'b0;
    dbg_addr_i          = '0;
    for (int i = 0; i < NUM_UNITS; i++) begin
      unit_result_i[i] = '0;
    end
    repeat (2) @(posedge clk_core);
    rst_core_n <= 1'b1;
    @(negedge clk_core);
    check_equal(token_o, 0, "token after reset");
    check_equal(unit_full_o, '0, "slots after reset");
    check_equal(wait_o, 1'b0, "wait_o after reset");

    in_order_retirement();
    busy_mask_tracking();
    back_pressure();
    trap_entry();
    return_and_flush();
    wait_for_irq();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Budget covers every directed test with margin
  initial begin
    repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk_core);
    $display("Watchdog expired after %0d cycles, tests did not complete",
             NUM_TESTS * TEST_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule
